// ==== exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXEC_WORD 32 // data path width
`define EXEC_ADDR 5 // 32 registers, r0 reads as zero

`define EXEC_FLUSH_CNT_W 4 // width of flush counters kept by checkers

`endif

// ==== exec_pkg.sv ====
package exec_pkg;

        typedef enum logic [2:0] {
                ADD    = 3'd0,
                SUB    = 3'd1,
                AND    = 3'd2,
                OR     = 3'd3,
                XOR    = 3'd4,
                SLL    = 3'd5,
                SRL    = 3'd6,
                PASS_B = 3'd7
        } alu_op_e;

        typedef enum logic [1:0] {
                SRC_REG = 2'd0,
                SRC_ACC = 2'd1,
                SRC_IMM = 2'd2,
                SRC_PC  = 2'd3
        } alu_src_e;

        // encoding 3 is never produced
        typedef enum logic [1:0] {
                FWD_DECODE = 2'd0,
                FWD_MEM    = 2'd1,
                FWD_WB     = 2'd2
        } fwd_src_e;

        typedef enum logic {
                SEL_REG_2 = 1'b0,
                SEL_REG_3 = 1'b1
        } store_sel_e;

        typedef enum logic [2:0] {
                BR_NONE   = 3'd0,
                BR_ALWAYS = 3'd1,
                BR_EQ     = 3'd2, // z set
                BR_NE     = 3'd3, // z clear
                BR_LT     = 3'd4, // n != v
                BR_GE     = 3'd5, // n == v
                BR_REG    = 3'd6  // target from operand 1
        } branch_cond_e;

        typedef struct packed {
                logic z;
                logic n;
                logic c;
                logic v;
        } status_t;

endpackage

// ==== fwd_bus_if.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

interface fwd_bus_if;
        logic                  mem_we;
        logic [`EXEC_ADDR-1:0] mem_dest;
        logic [`EXEC_WORD-1:0] mem_data;
        logic                  wb_we;
        logic [`EXEC_ADDR-1:0] wb_dest;
        logic [`EXEC_WORD-1:0] wb_data;

        modport source (
                output mem_we, mem_dest, mem_data,
                output wb_we, wb_dest, wb_data
        );

        modport forwarder (
                input mem_we, mem_dest, mem_data,
                input wb_we, wb_dest, wb_data
        );
endinterface

// ==== alu_flags_if.sv ====
`timescale 1ns/1ps

interface alu_flags_if;
        logic z;
        logic n;
        logic c;
        logic v;
        logic update; // load strobe, already qualified by valid

        modport producer (
                output z, n, c, v, update
        );

        modport consumer (
                input z, n, c, v, update
        );
endinterface

// ==== operand_forwarder.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module operand_forwarder (
        fwd_bus_if.forwarder            fwd,
        input  logic [`EXEC_ADDR-1:0]   reg_addr_1_i,
        input  logic [`EXEC_ADDR-1:0]   reg_addr_2_i,
        input  logic [`EXEC_ADDR-1:0]   reg_addr_3_i,
        input  logic [`EXEC_WORD-1:0]   reg_data_1_i,
        input  logic [`EXEC_WORD-1:0]   reg_data_2_i,
        input  logic [`EXEC_WORD-1:0]   reg_data_3_i,
        input  exec_pkg::store_sel_e    store_sel_i,
        output logic [`EXEC_WORD-1:0]   operand_1_o,
        output logic [`EXEC_WORD-1:0]   operand_2_o,
        output logic [`EXEC_WORD-1:0]   store_data_o
);

        logic [`EXEC_ADDR-1:0] addr [3];
        logic [`EXEC_WORD-1:0] dec_data [3];
        logic [`EXEC_WORD-1:0] opnd [3];
        exec_pkg::fwd_src_e    sel [3];

        assign addr     = '{reg_addr_1_i, reg_addr_2_i, reg_addr_3_i};
        assign dec_data = '{reg_data_1_i, reg_data_2_i, reg_data_3_i};

        always_comb begin
                for (int i = 0; i < 3; i++) begin
                        // MEM holds the younger result, so it wins over WB
                        sel[i] = exec_pkg::FWD_DECODE;
                        if (addr[i] != '0 && fwd.mem_we && addr[i] == fwd.mem_dest)
                                sel[i] = exec_pkg::FWD_MEM;
                        else if (addr[i] != '0 && fwd.wb_we && addr[i] == fwd.wb_dest)
                                sel[i] = exec_pkg::FWD_WB;

                        case (sel[i])
                                exec_pkg::FWD_MEM: opnd[i] = fwd.mem_data;
                                exec_pkg::FWD_WB:  opnd[i] = fwd.wb_data;
                                default:           opnd[i] = dec_data[i];
                        endcase

                        // r0 is hardwired, a write-back to it must never leak through
                        assert (addr[i] != '0 || opnd[i] == dec_data[i])
                        else $error("operand %0d forwarded for register 0", i + 1);
                end
        end

        assign operand_1_o = opnd[0];
        assign operand_2_o = opnd[1];

        always_comb begin
                if (store_sel_i == exec_pkg::SEL_REG_2)
                        store_data_o = opnd[1];
                else
                        store_data_o = opnd[2];
        end

endmodule

// ==== alu_wrapper.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module alu_wrapper (
        input  logic                    is_valid_i,
        input  logic                    update_flag_i,
        input  exec_pkg::alu_op_e       alu_op_i,
        input  exec_pkg::alu_src_e      src_1_sel_i,
        input  exec_pkg::alu_src_e      src_2_sel_i,
        input  logic [`EXEC_WORD-1:0]   operand_1_i,
        input  logic [`EXEC_WORD-1:0]   operand_2_i,
        input  logic [`EXEC_WORD-1:0]   accumulator_i,
        input  logic [`EXEC_WORD-1:0]   immediate_i,
        input  logic [`EXEC_WORD-1:0]   program_counter_i,
        output logic [`EXEC_WORD-1:0]   alu_result_o,
        alu_flags_if.producer           flags
);

        localparam int SHAMT_W = $clog2(`EXEC_WORD);
        localparam int MSB = `EXEC_WORD - 1;

        logic [`EXEC_WORD-1:0] src_a;
        logic [`EXEC_WORD-1:0] src_b;
        logic [`EXEC_WORD:0]   add_full;
        logic [`EXEC_WORD:0]   sub_full;
        logic                  add_ovf;
        logic                  sub_ovf;

        function automatic logic [`EXEC_WORD-1:0] pick_src(
                input exec_pkg::alu_src_e    sel,
                input logic [`EXEC_WORD-1:0] reg_val
        );
                case (sel)
                        exec_pkg::SRC_ACC: pick_src = accumulator_i;
                        exec_pkg::SRC_IMM: pick_src = immediate_i;
                        exec_pkg::SRC_PC:  pick_src = program_counter_i;
                        default:           pick_src = reg_val;
                endcase
        endfunction

        always_comb begin
                src_a = pick_src(src_1_sel_i, operand_1_i);
                src_b = pick_src(src_2_sel_i, operand_2_i);
        end

        assign add_full = {1'b0, src_a} + {1'b0, src_b};
        assign sub_full = {1'b0, src_a} + {1'b0, ~src_b} + 1'b1; // c = no borrow

        assign add_ovf = (src_a[MSB] == src_b[MSB]) && (add_full[MSB] != src_a[MSB]);
        assign sub_ovf = (src_a[MSB] != src_b[MSB]) && (sub_full[MSB] != src_a[MSB]);

        always_comb begin
                flags.c = 1'b0;
                flags.v = 1'b0;
                case (alu_op_i)
                        exec_pkg::ADD: begin
                                alu_result_o = add_full[MSB:0];
                                flags.c      = add_full[`EXEC_WORD];
                                flags.v      = add_ovf;
                        end
                        exec_pkg::SUB: begin
                                alu_result_o = sub_full[MSB:0];
                                flags.c      = sub_full[`EXEC_WORD];
                                flags.v      = sub_ovf;
                        end
                        exec_pkg::AND: alu_result_o = src_a & src_b;
                        exec_pkg::OR:  alu_result_o = src_a | src_b;
                        exec_pkg::XOR: alu_result_o = src_a ^ src_b;
                        exec_pkg::SLL: alu_result_o = src_a << src_b[SHAMT_W-1:0];
                        exec_pkg::SRL: alu_result_o = src_a >> src_b[SHAMT_W-1:0];
                        default:       alu_result_o = src_b; // PASS_B
                endcase
        end

        assign flags.z = (alu_result_o == '0);
        assign flags.n = alu_result_o[MSB];

        // bubbles never touch the status register
        assign flags.update = is_valid_i & update_flag_i;

endmodule

// ==== status_flags.sv ====
`timescale 1ns/1ps

module status_flags (
        input  logic                    clk_i,
        input  logic                    reset_i,
        alu_flags_if.consumer           flags,
        input  exec_pkg::branch_cond_e  cond_i,
        output logic                    cond_true_o
);

        exec_pkg::status_t status_q;

        always_ff @(posedge clk_i) begin
                if (reset_i)
                        status_q <= '0;
                else if (flags.update)
                        status_q <= '{z: flags.z, n: flags.n, c: flags.c, v: flags.v};
        end

        // decision uses flags left by older instructions only
        always_comb begin
                case (cond_i)
                        exec_pkg::BR_ALWAYS: cond_true_o = 1'b1;
                        exec_pkg::BR_REG:    cond_true_o = 1'b1;
                        exec_pkg::BR_EQ:     cond_true_o = status_q.z;
                        exec_pkg::BR_NE:     cond_true_o = !status_q.z;
                        exec_pkg::BR_LT:     cond_true_o = status_q.n ^ status_q.v;
                        exec_pkg::BR_GE:     cond_true_o = !(status_q.n ^ status_q.v);
                        default:             cond_true_o = 1'b0; // BR_NONE
                endcase
        end

        a_hold_without_update: assert property (
                @(posedge clk_i) disable iff (reset_i)
                !flags.update |=> $stable(status_q)
        ) else $error("status flags changed without an update strobe");

endmodule

// ==== branch_controller.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module branch_controller (
        input  logic                    clk_i,
        input  logic                    reset_i,
        input  logic                    is_valid_i,
        input  exec_pkg::branch_cond_e  cond_i,
        input  logic                    cond_true_i,
        input  logic [`EXEC_WORD-1:0]   program_counter_i, // already points at next instr
        input  logic [`EXEC_WORD-1:0]   immediate_i,
        input  logic [`EXEC_WORD-1:0]   operand_1_i,
        output logic                    take_branch_o,
        output logic                    flush_pipeline_o,
        output logic [`EXEC_WORD-1:0]   target_pc_o
);

        logic [`EXEC_WORD-1:0] target;
        logic                  taken;

        always_comb begin
                if (cond_i == exec_pkg::BR_REG)
                        target = operand_1_i; // forwarded register value
                else
                        target = program_counter_i + immediate_i;
        end

        // BR_NONE already evaluates false in the flag block
        assign taken = is_valid_i & cond_true_i;

        always_ff @(posedge clk_i) begin
                if (reset_i) begin
                        take_branch_o    <= 1'b0;
                        flush_pipeline_o <= 1'b0;
                end else begin
                        take_branch_o    <= taken;
                        flush_pipeline_o <= taken; // younger instrs are wrong path
                end
        end

        always_ff @(posedge clk_i) begin
                target_pc_o <= taken ? target : program_counter_i;
        end

        a_flush_matches_take: assert property (
                @(posedge clk_i) disable iff (reset_i)
                flush_pipeline_o == take_branch_o
        ) else $error("flush and take_branch disagree");

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module execute_stage (
        input  logic                    clk_i,
        input  logic                    reset_i,
        input  logic                    is_valid_i,
        input  logic                    update_flag_i,
        input  exec_pkg::alu_op_e       alu_op_i,
        input  exec_pkg::alu_src_e      src_1_sel_i,
        input  exec_pkg::alu_src_e      src_2_sel_i,
        input  exec_pkg::branch_cond_e  branch_cond_i,
        input  exec_pkg::store_sel_e    store_sel_i,
        input  logic [`EXEC_ADDR-1:0]   reg_addr_1_i,
        input  logic [`EXEC_ADDR-1:0]   reg_addr_2_i,
        input  logic [`EXEC_ADDR-1:0]   reg_addr_3_i,
        input  logic [`EXEC_WORD-1:0]   reg_data_1_i,
        input  logic [`EXEC_WORD-1:0]   reg_data_2_i,
        input  logic [`EXEC_WORD-1:0]   reg_data_3_i,
        input  logic                    mem_we_i,
        input  logic [`EXEC_ADDR-1:0]   mem_dest_i,
        input  logic [`EXEC_WORD-1:0]   mem_data_i,
        input  logic                    wb_we_i,
        input  logic [`EXEC_ADDR-1:0]   wb_dest_i,
        input  logic [`EXEC_WORD-1:0]   wb_data_i,
        input  logic [`EXEC_WORD-1:0]   accumulator_i,
        input  logic [`EXEC_WORD-1:0]   immediate_i,
        input  logic [`EXEC_WORD-1:0]   program_counter_i,
        output logic [`EXEC_WORD-1:0]   alu_result_o,
        output logic [`EXEC_WORD-1:0]   store_data_o,
        output logic                    take_branch_o,
        output logic                    flush_pipeline_o,
        output logic [`EXEC_WORD-1:0]   target_pc_o
);

        logic [`EXEC_WORD-1:0] operand_1;
        logic [`EXEC_WORD-1:0] operand_2;
        logic                  cond_true;

        fwd_bus_if   u_fwd_bus ();
        alu_flags_if u_alu_flags ();

        assign u_fwd_bus.mem_we   = mem_we_i;
        assign u_fwd_bus.mem_dest = mem_dest_i;
        assign u_fwd_bus.mem_data = mem_data_i;
        assign u_fwd_bus.wb_we    = wb_we_i;
        assign u_fwd_bus.wb_dest  = wb_dest_i;
        assign u_fwd_bus.wb_data  = wb_data_i;

        operand_forwarder u_forwarder (
                .fwd          (u_fwd_bus.forwarder),
                .reg_addr_1_i (reg_addr_1_i),
                .reg_addr_2_i (reg_addr_2_i),
                .reg_addr_3_i (reg_addr_3_i),
                .reg_data_1_i (reg_data_1_i),
                .reg_data_2_i (reg_data_2_i),
                .reg_data_3_i (reg_data_3_i),
                .store_sel_i  (store_sel_i),
                .operand_1_o  (operand_1),
                .operand_2_o  (operand_2),
                .store_data_o (store_data_o)
        );

        alu_wrapper u_alu (
                .is_valid_i        (is_valid_i),
                .update_flag_i     (update_flag_i),
                .alu_op_i          (alu_op_i),
                .src_1_sel_i       (src_1_sel_i),
                .src_2_sel_i       (src_2_sel_i),
                .operand_1_i       (operand_1),
                .operand_2_i       (operand_2),
                .accumulator_i     (accumulator_i),
                .immediate_i       (immediate_i),
                .program_counter_i (program_counter_i),
                .alu_result_o      (alu_result_o),
                .flags             (u_alu_flags.producer)
        );

        status_flags u_status (
                .clk_i       (clk_i),
                .reset_i     (reset_i),
                .flags       (u_alu_flags.consumer),
                .cond_i      (branch_cond_i),
                .cond_true_o (cond_true)
        );

        branch_controller u_branch (
                .clk_i             (clk_i),
                .reset_i           (reset_i),
                .is_valid_i        (is_valid_i),
                .cond_i            (branch_cond_i),
                .cond_true_i       (cond_true),
                .program_counter_i (program_counter_i),
                .immediate_i       (immediate_i),
                .operand_1_i       (operand_1),
                .take_branch_o     (take_branch_o),
                .flush_pipeline_o  (flush_pipeline_o),
                .target_pc_o       (target_pc_o)
        );

endmodule

// ==== tb_execute_stage.sv ====
`timescale 1ns/1ps
`include "exec_cfg.svh"

module tb_execute_stage;

        localparam int W           = `EXEC_WORD;
        localparam int CLK_PERIOD  = 4;
        localparam int TEST_CYCLES = 2000;
        localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 200;
        localparam int RAND_CYCLES = 1500;

        logic                   clk_i = 1'b0;
        logic                   reset_i;
        logic                   is_valid_i;
        logic                   update_flag_i;
        exec_pkg::alu_op_e      alu_op_i;
        exec_pkg::alu_src_e     src_1_sel_i;
        exec_pkg::alu_src_e     src_2_sel_i;
        exec_pkg::branch_cond_e branch_cond_i;
        exec_pkg::store_sel_e   store_sel_i;
        logic [`EXEC_ADDR-1:0]  reg_addr_1_i, reg_addr_2_i, reg_addr_3_i;
        logic [W-1:0]           reg_data_1_i, reg_data_2_i, reg_data_3_i;
        logic                   mem_we_i, wb_we_i;
        logic [`EXEC_ADDR-1:0]  mem_dest_i, wb_dest_i;
        logic [W-1:0]           mem_data_i, wb_data_i;
        logic [W-1:0]           accumulator_i, immediate_i, program_counter_i;
        logic [W-1:0]           alu_result_o, store_data_o, target_pc_o;
        logic                   take_branch_o, flush_pipeline_o;

        // reference model state and expectations
        logic [W-1:0]      op1, op2, op3, src_a, src_b;
        logic [W-1:0]      exp_alu, exp_store, exp_target, br_target;
        exec_pkg::status_t model_flags, new_flags;
        logic              cond_hit, exp_take;
        int                errors = 0;

        execute_stage u_dut (.*);

        always #(CLK_PERIOD / 2) clk_i = ~clk_i;

        function automatic logic [W-1:0] forward(input logic [`EXEC_ADDR-1:0] addr,
                                                 input logic [W-1:0] dec);
                if (addr == '0)
                        return dec; // r0 is never forwarded
                if (mem_we_i && mem_dest_i == addr)
                        return mem_data_i;
                if (wb_we_i && wb_dest_i == addr)
                        return wb_data_i;
                return dec;
        endfunction

        function automatic logic [W-1:0] src_value(input exec_pkg::alu_src_e sel,
                                                   input logic [W-1:0] reg_val);
                case (sel)
                        exec_pkg::SRC_REG: return reg_val;
                        exec_pkg::SRC_ACC: return accumulator_i;
                        exec_pkg::SRC_IMM: return immediate_i;
                        default:           return program_counter_i;
                endcase
        endfunction

        function automatic logic [W-1:0] alu_calc(input exec_pkg::alu_op_e op,
                                                  input logic [W-1:0] a, input logic [W-1:0] b);
                case (op)
                        exec_pkg::ADD: return a + b;
                        exec_pkg::SUB: return a - b;
                        exec_pkg::AND: return a & b;
                        exec_pkg::OR:  return a | b;
                        exec_pkg::XOR: return a ^ b;
                        exec_pkg::SLL: return a << (b % W);
                        exec_pkg::SRL: return a >> (b % W);
                        default:       return b;
                endcase
        endfunction

        function automatic exec_pkg::status_t flags_of(input exec_pkg::alu_op_e op,
                        input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] res);
                exec_pkg::status_t f;
                logic [W:0]        wide;
                f   = '0;
                f.z = (res == '0);
                f.n = res[W-1];
                if (op == exec_pkg::ADD) begin
                        f.c  = ((a + b) < a); // unsigned sum wrapped around
                        wide = {a[W-1], a} + {b[W-1], b}; // overflow when top bits split
                        f.v  = wide[W] ^ wide[W-1];
                end else if (op == exec_pkg::SUB) begin
                        f.c  = (a >= b); // carry means no borrow
                        wide = {a[W-1], a} - {b[W-1], b};
                        f.v  = wide[W] ^ wide[W-1];
                end
                return f;
        endfunction

        always_comb begin
                op1       = forward(reg_addr_1_i, reg_data_1_i);
                op2       = forward(reg_addr_2_i, reg_data_2_i);
                op3       = forward(reg_addr_3_i, reg_data_3_i);
                exp_store = (store_sel_i == exec_pkg::SEL_REG_3) ? op3 : op2;
                src_a     = src_value(src_1_sel_i, op1);
                src_b     = src_value(src_2_sel_i, op2);
                exp_alu   = alu_calc(alu_op_i, src_a, src_b);
                new_flags = flags_of(alu_op_i, src_a, src_b, exp_alu);
                case (branch_cond_i)
                        exec_pkg::BR_ALWAYS, exec_pkg::BR_REG: cond_hit = 1'b1;
                        exec_pkg::BR_EQ: cond_hit = model_flags.z;
                        exec_pkg::BR_NE: cond_hit = !model_flags.z;
                        exec_pkg::BR_LT: cond_hit = (model_flags.n != model_flags.v);
                        exec_pkg::BR_GE: cond_hit = (model_flags.n == model_flags.v);
                        default:         cond_hit = 1'b0;
                endcase
                br_target = (branch_cond_i == exec_pkg::BR_REG) ? op1
                                                                : program_counter_i + immediate_i;
        end

        always @(posedge clk_i) begin
                if (reset_i) begin
                        model_flags <= '0;
                        exp_take    <= 1'b0;
                end else begin
                        if (is_valid_i && update_flag_i)
                                model_flags <= new_flags;
                        exp_take <= is_valid_i && cond_hit;
                end
                exp_target <= (is_valid_i && cond_hit) ? br_target : program_counter_i;
        end

        task automatic report_mismatch(input string what, input logic [W-1:0] got,
                                       input logic [W-1:0] exp);
                errors++;
                $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        endtask

        chk_alu: assert property (@(posedge clk_i) disable iff (reset_i) alu_result_o == exp_alu)
                else report_mismatch("alu_result_o", $sampled(alu_result_o), $sampled(exp_alu));
        chk_store: assert property (@(posedge clk_i) disable iff (reset_i)
                        store_data_o == exp_store)
                else report_mismatch("store_data_o", $sampled(store_data_o), $sampled(exp_store));
        chk_take: assert property (@(posedge clk_i) disable iff (reset_i)
                        take_branch_o == exp_take)
                else report_mismatch("take_branch_o", W'($sampled(take_branch_o)),
                                     W'($sampled(exp_take)));
        chk_flush: assert property (@(posedge clk_i) disable iff (reset_i)
                        flush_pipeline_o == exp_take)
                else report_mismatch("flush_pipeline_o", W'($sampled(flush_pipeline_o)),
                                     W'($sampled(exp_take)));
        chk_target: assert property (@(posedge clk_i) disable iff (reset_i)
                        target_pc_o == exp_target)
                else report_mismatch("target_pc_o", $sampled(target_pc_o), $sampled(exp_target));
        chk_reset_quiet: assert property (@(posedge clk_i)
                        $fell(reset_i) |-> !take_branch_o && !flush_pipeline_o)
                else begin
                        errors++;
                        $display("[FAIL] %0t ns: redirect active in the first cycle after reset",
                                 $time);
                end

        // small address range so collisions with MEM and WB happen often
        function automatic logic [`EXEC_ADDR-1:0] pick_addr();
                if ($urandom_range(0, 7) == 0)
                        return `EXEC_ADDR'($urandom());
                return `EXEC_ADDR'($urandom_range(0, 3));
        endfunction

        function automatic logic [W-1:0] pick_word();
                case ($urandom_range(0, 7))
                        0:       return '0;
                        1:       return {1'b1, {(W-1){1'b0}}};
                        2:       return '1;
                        3:       return W'(1);
                        default: return W'($urandom());
                endcase
        endfunction

        task automatic apply_random();
                is_valid_i        <= ($urandom_range(0, 3) != 0);
                update_flag_i     <= 1'($urandom_range(0, 1));
                alu_op_i          <= exec_pkg::alu_op_e'($urandom_range(0, 7));
                src_1_sel_i       <= exec_pkg::alu_src_e'($urandom_range(0, 3));
                src_2_sel_i       <= exec_pkg::alu_src_e'($urandom_range(0, 3));
                branch_cond_i     <= exec_pkg::branch_cond_e'($urandom_range(0, 6));
                store_sel_i       <= exec_pkg::store_sel_e'($urandom_range(0, 1));
                reg_addr_1_i      <= pick_addr();
                reg_addr_2_i      <= pick_addr();
                reg_addr_3_i      <= pick_addr();
                reg_data_1_i      <= pick_word();
                reg_data_2_i      <= pick_word();
                reg_data_3_i      <= pick_word();
                mem_we_i          <= 1'($urandom_range(0, 1));
                mem_dest_i        <= pick_addr();
                mem_data_i        <= pick_word();
                wb_we_i           <= 1'($urandom_range(0, 1));
                wb_dest_i         <= pick_addr();
                wb_data_i         <= pick_word();
                accumulator_i     <= pick_word();
                immediate_i       <= pick_word();
                program_counter_i <= W'($urandom());
        endtask

        initial begin
                void'($urandom(32'haa87_56cb));
                reset_i       <= 1'b1;
                // reset has to mask this taken branch and its flag update
                is_valid_i    <= 1'b1;
                update_flag_i <= 1'b1;
                alu_op_i      <= exec_pkg::PASS_B;
                src_1_sel_i   <= exec_pkg::SRC_REG;
                src_2_sel_i   <= exec_pkg::SRC_IMM; // zero result would set z
                branch_cond_i <= exec_pkg::BR_ALWAYS;
                store_sel_i   <= exec_pkg::SEL_REG_2;
                {reg_addr_1_i, reg_addr_2_i, reg_addr_3_i} <= '0;
                {reg_data_1_i, reg_data_2_i, reg_data_3_i} <= '0;
                {mem_we_i, mem_dest_i, mem_data_i} <= '0;
                {wb_we_i, wb_dest_i, wb_data_i} <= '0;
                {accumulator_i, immediate_i, program_counter_i} <= '0;
                repeat (16) @(posedge clk_i);
                reset_i       <= 1'b0;
                is_valid_i    <= 1'b0;
                update_flag_i <= 1'b0;

                // conditional branches right after reset see cleared flags
                for (int k = 0; k < 4; k++) begin
                        @(posedge clk_i);
                        apply_random();
                        is_valid_i    <= 1'b1;
                        update_flag_i <= 1'b0;
                        branch_cond_i <= exec_pkg::branch_cond_e'(k + 2);
                end

                for (int op = 0; op < 8; op++)
                        for (int s1 = 0; s1 < 4; s1++)
                                for (int s2 = 0; s2 < 4; s2++) begin
                                        @(posedge clk_i);
                                        apply_random();
                                        is_valid_i  <= 1'b1;
                                        alu_op_i    <= exec_pkg::alu_op_e'(op);
                                        src_1_sel_i <= exec_pkg::alu_src_e'(s1);
                                        src_2_sel_i <= exec_pkg::alu_src_e'(s2);
                                end

                repeat (RAND_CYCLES) begin
                        @(posedge clk_i);
                        apply_random();
                end

                @(posedge clk_i);
                is_valid_i <= 1'b0;
                repeat (4) @(posedge clk_i);
                $display("run finished with %0d errors", errors);
                if (errors == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

        initial begin
                #(WATCHDOG_NS);
                $display("watchdog expired after %0d ns before the stimulus ended", WATCHDOG_NS);
                $display("Simulation failed");
                $finish;
        end

endmodule

// ==== sources.f ====
+incdir+.
exec_pkg.sv
fwd_bus_if.sv
alu_flags_if.sv
operand_forwarder.sv
alu_wrapper.sv
status_flags.sv
branch_controller.sv
execute_stage.sv
tb_execute_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
EXE=sim_execute_stage

verilator --binary --timing --assert -Wno-fatal \
        -f sources.f --top-module tb_execute_stage \
        -Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
        echo "simulation exited with status $run_status"
        exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
        exit 1
fi
exit 0
